//--- dcache.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_line_ram.sv
verilog/dcache_state_bits.sv
verilog/dcache_mem_port.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/clk_gen.sv
sim/mem_model.sv
sim/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator.
# The exit status is the simulator's, so a failing run returns non-zero.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f dcache.f \
  --top-module tb_dcache \
  -Mdir obj_dir \
  -o tb_dcache

./obj_dir/tb_dcache

//--- sim/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tb_dcache;
  import dcache_pkg::*;

  localparam int          N_REQ          = 400;
  localparam int          N_ADDR         = 24;
  localparam int          TIMEOUT_CYCLES = N_REQ * 20;
  localparam logic [31:0] FILL_KEY       = 32'h5a17_3c96;

  logic        clk;
  logic        rst;
  logic        req   = 1'b0;
  logic        we    = 1'b0;
  addr_t       addr  = '0;
  word_t       wdata = '0;
  bmask_t      wmask = '0;
  logic        stall;
  word_t       rdata;
  logic        mem_valid;
  logic [31:0] mem_addr;
  word_t       mem_wdata;
  bmask_t      mem_we;
  word_t       mem_rdata;
  logic        mem_ready;

  // Reference model: architectural words plus a mirror of the cache state
  word_t                arch [logic [16:0]];
  logic [`DC_LINES-1:0] m_valid = '0;
  logic [`DC_LINES-1:0] m_dirty = '0;
  tag_t                 m_tag [`DC_LINES];
  logic [31:0]          exp_addr_q [$];
  bmask_t               exp_we_q [$];
  word_t                exp_data_q [$];
  addr_t                pool [N_ADDR];
  int                   cycles = 0;

  clk_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
    .clk_i       (clk),
    .rst_i       (rst),
    .mem_valid_i (mem_valid),
    .mem_addr_i  (mem_addr),
    .mem_wdata_i (mem_wdata),
    .mem_we_i    (mem_we),
    .mem_rdata_o (mem_rdata),
    .mem_ready_o (mem_ready)
  );

  dcache_top dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_i       (req),
    .we_i        (we),
    .addr_i      (addr),
    .wdata_i     (wdata),
    .wmask_i     (wmask),
    .stall_o     (stall),
    .rdata_o     (rdata),
    .mem_valid_o (mem_valid),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_we_o    (mem_we),
    .mem_rdata_i (mem_rdata),
    .mem_ready_i (mem_ready)
  );

  function automatic word_t init_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ FILL_KEY;
  endfunction

  function automatic word_t arch_word(input logic [16:0] wa);
    if (arch.exists(wa)) begin
      return arch[wa];
    end
    return init_word({`DC_MEM_BASE, wa, 2'b00});
  endfunction

  // Zero mask writes the whole word
  function automatic word_t merge_word(input word_t old, input word_t d, input bmask_t m);
    word_t  res;
    bmask_t en;
    en  = (m == 4'h0) ? 4'hf : m;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (en[b]) begin
        res[8*b +: 8] = d[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, want);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_mem_req();
    if (exp_addr_q.size() == 0) begin
      $display("Unexpected memory request at %0t to address %h", $time, mem_addr);
      $display("=== FAIL ===");
      $fatal(1, "unexpected memory request");
    end else begin
      check_eq(mem_addr, exp_addr_q[0], "memory address");
      check_eq(32'(mem_we), 32'(exp_we_q[0]), "memory write enable");
      if (exp_we_q[0] != 4'h0) begin
        check_eq(mem_wdata, exp_data_q[0], "write-back data");
      end
      void'(exp_addr_q.pop_front());
      void'(exp_we_q.pop_front());
      void'(exp_data_q.pop_front());
    end
  endtask

  task automatic run_request(input logic wr, input addr_t a, input word_t d, input bmask_t m);
    index_t      ix;
    tag_t        tg;
    logic [16:0] wa;
    logic        hit;
    int          stalls;
    logic        saw_mem;
    logic        done;
    ix  = a[`DC_IDX_HI:`DC_IDX_LO];
    tg  = a[`DC_TAG_HI:`DC_TAG_LO];
    wa  = a[`DC_TAG_HI:`DC_IDX_LO];
    hit = m_valid[ix] && (m_tag[ix] == tg);
    if (!hit) begin
      // Dirty victim goes back to memory before the fetch
      if (m_valid[ix] && m_dirty[ix]) begin
        exp_addr_q.push_back({`DC_MEM_BASE, m_tag[ix], ix, 2'b00});
        exp_we_q.push_back(4'hf);
        exp_data_q.push_back(arch_word({m_tag[ix], ix}));
      end
      exp_addr_q.push_back({`DC_MEM_BASE, tg, ix, 2'b00});
      exp_we_q.push_back(4'h0);
      exp_data_q.push_back(32'h0);
    end
    @(posedge clk);
    req   <= 1'b1;
    we    <= wr;
    addr  <= a;
    wdata <= d;
    wmask <= m;
    stalls  = 0;
    saw_mem = 1'b0;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (mem_valid) begin
        saw_mem = 1'b1;
      end
      if (mem_valid && mem_ready) begin
        check_mem_req();
      end
      if (stall) begin
        stalls++;
      end else begin
        done = 1'b1;
      end
    end
    if (!wr) begin
      check_eq(rdata, arch_word(wa), "read data");
    end
    if (hit) begin
      check_eq(stalls, wr ? 3 : 2, "stall cycles of a hit");
      check_eq(32'(saw_mem), 32'd0, "memory access on a hit");
    end else begin
      check_eq(exp_addr_q.size(), 0, "memory requests still expected");
    end
    // Completing edge
    @(posedge clk);
    req <= 1'b0;
    if (wr) begin
      arch[wa] = merge_word(arch_word(wa), d, m);
    end
    m_dirty[ix] = hit ? (m_dirty[ix] | wr) : wr;
    m_valid[ix] = 1'b1;
    m_tag[ix]   = tg;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run hung", cycles);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

  initial begin
    tag_t   t;
    index_t ix;
    void'($urandom(6));
    for (int k = 0; k < N_ADDR; k++) begin
      t  = tag_t'($urandom_range(0, 255));
      // Few indices, so tags collide and lines get evicted
      ix = index_t'($urandom_range(0, 5) * 83);
      pool[k] = {t, ix, 2'b00};
    end
    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end
    check_eq(32'(stall), 32'd0, "stall after reset");
    check_eq(32'(mem_valid), 32'd0, "mem_valid after reset");
    for (int n = 0; n < N_REQ; n++) begin
      run_request(1'($urandom_range(0, 1)), pool[$urandom_range(0, N_ADDR - 1)],
                  $urandom(), bmask_t'($urandom_range(0, 15)));
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- sim/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
  parameter logic [31:0] FILL_KEY = 32'h0
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               mem_valid_i,
  input  logic [31:0]        mem_addr_i,
  input  dcache_pkg::word_t  mem_wdata_i,
  input  dcache_pkg::bmask_t mem_we_i,
  output dcache_pkg::word_t  mem_rdata_o,
  output logic               mem_ready_o
);
  import dcache_pkg::*;

  // Only written words are stored, the rest come from the fill pattern
  word_t store [logic [31:0]];
  logic  ready_q = 1'b0;
  word_t rdata_q = '0;
  logic  busy_q  = 1'b0;
  int    wait_q  = 0;

  assign mem_ready_o = ready_q;
  assign mem_rdata_o = rdata_q;

  function automatic word_t fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ FILL_KEY;
  endfunction

  function automatic word_t read_word(input logic [31:0] a);
    if (store.exists(a)) begin
      return store[a];
    end
    return fill_word(a);
  endfunction

  always @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
      busy_q  <= 1'b0;
      wait_q  <= 0;
    end else if (ready_q) begin
      // Handshake edge
      ready_q <= 1'b0;
      busy_q  <= 1'b0;
      if (mem_we_i != 4'h0) begin
        store[mem_addr_i] = mem_wdata_i;
      end
    end else if (mem_valid_i && !busy_q) begin
      busy_q <= 1'b1;
      wait_q <= $urandom_range(1, 6);
    end else if (busy_q) begin
      if (wait_q == 1) begin
        ready_q <= 1'b1;
        rdata_q <= read_word(mem_addr_i);
      end
      wait_q <= wait_q - 1;
    end
  end

endmodule

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  logic clk_q = 1'b0;
  logic rst_q = 1'b1;

  assign clk_o = clk_q;
  assign rst_o = rst_q;

  // 40 ns period
  initial begin
    forever #20 clk_q = ~clk_q;
  end

  initial begin
    repeat (RESET_CYCLES) @(posedge clk_q);
    rst_q <= 1'b0;
  end

endmodule

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               req_i,
  input  logic               we_i,
  input  dcache_pkg::addr_t  addr_i,
  input  dcache_pkg::word_t  wdata_i,
  input  dcache_pkg::bmask_t wmask_i,
  output logic               stall_o,
  output dcache_pkg::word_t  rdata_o,
  output logic               mem_valid_o,
  output logic [31:0]        mem_addr_o,
  output dcache_pkg::word_t  mem_wdata_o,
  output dcache_pkg::bmask_t mem_we_o,
  input  dcache_pkg::word_t  mem_rdata_i,
  input  logic               mem_ready_i
);
  import dcache_pkg::*;

  logic        rd_en;
  index_t      rd_idx;
  line_entry_t rd_entry;
  logic        wr_en;
  index_t      wr_idx;
  bmask_t      wr_mask;
  line_entry_t wr_entry;
  logic        upd;
  logic        upd_valid;
  logic        upd_dirty;
  logic        line_valid;
  logic        line_dirty;
  logic        mem_load;
  mem_req_t    mem_req;
  logic        mem_done;
  word_t       mem_word;

  dcache_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .wmask_i      (wmask_i),
    .rd_entry_i   (rd_entry),
    .line_valid_i (line_valid),
    .line_dirty_i (line_dirty),
    .mem_done_i   (mem_done),
    .mem_word_i   (mem_word),
    .stall_o      (stall_o),
    .rdata_o      (rdata_o),
    .rd_en_o      (rd_en),
    .rd_idx_o     (rd_idx),
    .wr_en_o      (wr_en),
    .wr_idx_o     (wr_idx),
    .wr_mask_o    (wr_mask),
    .wr_entry_o   (wr_entry),
    .upd_o        (upd),
    .upd_valid_o  (upd_valid),
    .upd_dirty_o  (upd_dirty),
    .mem_load_o   (mem_load),
    .mem_req_o    (mem_req)
  );

  dcache_line_ram u_line_ram (
    .clk_i      (clk_i),
    .rd_en_i    (rd_en),
    .rd_idx_i   (rd_idx),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_mask_i  (wr_mask),
    .wr_entry_i (wr_entry),
    .rd_entry_o (rd_entry)
  );

  // Valid and dirty of the requested index
  dcache_state_bits u_state_bits (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .idx_i       (addr_i[`DC_IDX_HI:`DC_IDX_LO]),
    .upd_i       (upd),
    .upd_valid_i (upd_valid),
    .upd_dirty_i (upd_dirty),
    .valid_o     (line_valid),
    .dirty_o     (line_dirty)
  );

  dcache_mem_port u_mem_port (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .load_i      (mem_load),
    .req_i       (mem_req),
    .mem_rdata_i (mem_rdata_i),
    .mem_ready_i (mem_ready_i),
    .mem_valid_o (mem_valid_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_we_o    (mem_we_o),
    .done_o      (mem_done),
    .word_o      (mem_word)
  );

endmodule

//--- verilog/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  dcache_pkg::addr_t       addr_i,
  input  dcache_pkg::word_t       wdata_i,
  input  dcache_pkg::bmask_t      wmask_i,
  input  dcache_pkg::line_entry_t rd_entry_i,
  input  logic                    line_valid_i,
  input  logic                    line_dirty_i,
  input  logic                    mem_done_i,
  input  dcache_pkg::word_t       mem_word_i,
  output logic                    stall_o,
  output dcache_pkg::word_t       rdata_o,
  output logic                    rd_en_o,
  output dcache_pkg::index_t      rd_idx_o,
  output logic                    wr_en_o,
  output dcache_pkg::index_t      wr_idx_o,
  output dcache_pkg::bmask_t      wr_mask_o,
  output dcache_pkg::line_entry_t wr_entry_o,
  output logic                    upd_o,
  output logic                    upd_valid_o,
  output logic                    upd_dirty_o,
  output logic                    mem_load_o,
  output dcache_pkg::mem_req_t    mem_req_o
);
  import dcache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        rd_pend_q;
  logic        hit;
  tag_t        req_tag;
  index_t      req_idx;
  bmask_t      core_mask;
  logic [31:0] wb_addr;
  logic [31:0] fill_addr;

  assign req_tag   = addr_i[`DC_TAG_HI:`DC_TAG_LO];
  assign req_idx   = addr_i[`DC_IDX_HI:`DC_IDX_LO];
  assign hit       = line_valid_i && (rd_entry_i.tag == req_tag);
  // Zero mask means a full word
  assign core_mask = (|wmask_i) ? wmask_i : 4'hf;
  assign wb_addr   = {`DC_MEM_BASE, rd_entry_i.tag, req_idx, 2'b00};
  assign fill_addr = {`DC_MEM_BASE, req_tag, req_idx, 2'b00};

  assign rd_idx_o = req_idx;
  assign wr_idx_o = req_idx;
  assign stall_o  = (state_q == IDLE) ? req_i : (state_q != DONE);

  always_comb begin
    state_d     = state_q;
    rd_en_o     = 1'b0;
    wr_en_o     = 1'b0;
    wr_mask_o   = 4'hf;
    wr_entry_o  = '{tag: req_tag, word: wdata_i};
    upd_o       = 1'b0;
    upd_valid_o = 1'b1;
    upd_dirty_o = 1'b0;
    mem_load_o  = 1'b0;
    mem_req_o   = '{addr: fill_addr, data: '0, we: 1'b0};
    case (state_q)
      IDLE: begin
        if (req_i) begin
          rd_en_o = 1'b1;
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        // Back from a refill the RAM still has to be read
        if (!rd_pend_q) begin
          rd_en_o = 1'b1;
        end else if (hit) begin
          state_d = we_i ? WRITE : DONE;
        end else if (line_valid_i && line_dirty_i) begin
          mem_load_o = 1'b1;
          mem_req_o  = '{addr: wb_addr, data: rd_entry_i.word, we: 1'b1};
          state_d    = WRITEBACK;
        end else begin
          mem_load_o = 1'b1;
          state_d    = REFILL;
        end
      end
      WRITEBACK: begin
        if (mem_done_i) begin
          mem_load_o = 1'b1;
          state_d    = REFILL;
        end
      end
      REFILL: begin
        if (mem_done_i) begin
          wr_en_o         = 1'b1;
          wr_entry_o.word = mem_word_i;
          upd_o           = 1'b1;
          state_d         = we_i ? WRITE : LOOKUP;
        end
      end
      WRITE: begin
        wr_en_o     = 1'b1;
        wr_mask_o   = core_mask;
        upd_o       = 1'b1;
        upd_dirty_o = 1'b1;
        state_d     = DONE;
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      rd_pend_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      rd_pend_q <= rd_en_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == LOOKUP && rd_pend_q && hit) begin
      rdata_o <= rd_entry_i.word;
    end
  end

  // Refilled line must hit on the lookup that follows
  a_refill_hits: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == LOOKUP && rd_pend_q && $past(state_q, 2) == REFILL) |-> hit);

  // A written line reads back valid and dirty
  a_write_marks_dirty: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == WRITE) |=> (line_valid_i && line_dirty_i));

endmodule

//--- verilog/dcache_mem_port.sv
`timescale 1ns/1ps

module dcache_mem_port (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 load_i,
  input  dcache_pkg::mem_req_t req_i,
  input  dcache_pkg::word_t    mem_rdata_i,
  input  logic                 mem_ready_i,
  output logic                 mem_valid_o,
  output logic [31:0]          mem_addr_o,
  output dcache_pkg::word_t    mem_wdata_o,
  output dcache_pkg::bmask_t   mem_we_o,
  output logic                 done_o,
  output dcache_pkg::word_t    word_o
);

  logic accept;

  assign accept = mem_valid_o && mem_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mem_valid_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      // Done follows the ready cycle, valid is already low then
      done_o <= accept;
      if (load_i) begin
        mem_valid_o <= 1'b1;
      end else if (accept) begin
        mem_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      mem_addr_o  <= req_i.addr;
      mem_wdata_o <= req_i.data;
      mem_we_o    <= {4{req_i.we}};
    end
    if (accept) begin
      word_o <= mem_rdata_i;
    end
  end

  a_load_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    load_i |-> !mem_valid_o);

endmodule

//--- verilog/dcache_state_bits.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_state_bits (
  input  logic               clk_i,
  input  logic               rst_i,
  input  dcache_pkg::index_t idx_i,
  input  logic               upd_i,
  input  logic               upd_valid_i,
  input  logic               upd_dirty_i,
  output logic               valid_o,
  output logic               dirty_o
);

  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;

  // Lookup of the current index, no delay
  assign valid_o = valid_q[idx_i];
  assign dirty_o = dirty_q[idx_i];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (upd_i) begin
      valid_q[idx_i] <= upd_valid_i;
      dirty_q[idx_i] <= upd_dirty_i;
    end
  end

  a_dirty_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    (dirty_q & ~valid_q) == '0);

endmodule

//--- verilog/dcache_line_ram.sv
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_line_ram (
  input  logic                    clk_i,
  input  logic                    rd_en_i,
  input  dcache_pkg::index_t      rd_idx_i,
  input  logic                    wr_en_i,
  input  dcache_pkg::index_t      wr_idx_i,
  input  dcache_pkg::bmask_t      wr_mask_i,
  input  dcache_pkg::line_entry_t wr_entry_i,
  output dcache_pkg::line_entry_t rd_entry_o
);
  import dcache_pkg::*;

  line_entry_t mem_q [`DC_LINES];

  // Tag always written, data bytes by mask
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_idx_i].tag <= wr_entry_i.tag;
      for (int b = 0; b < 4; b++) begin
        if (wr_mask_i[b]) begin
          mem_q[wr_idx_i].word[8*b +: 8] <= wr_entry_i.word[8*b +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_entry_o <= mem_q[rd_idx_i];
    end
  end

  a_no_rw_collision: assert property (@(posedge clk_i)
    !(rd_en_i && wr_en_i && (rd_idx_i == wr_idx_i)));

endmodule

//--- verilog/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

  typedef logic [31:0]                       word_t;
  typedef logic [`DC_TAG_HI:0]               addr_t;
  typedef logic [`DC_TAG_HI-`DC_TAG_LO:0]    tag_t;
  typedef logic [`DC_IDX_HI-`DC_IDX_LO:0]    index_t;
  typedef logic [3:0]                        bmask_t;

  typedef enum logic [2:0] {
    IDLE, LOOKUP, WRITEBACK, REFILL, WRITE, DONE
  } ctrl_state_e;

  // One RAM word, tag above data
  typedef struct packed {
    tag_t  tag;
    word_t word;
  } line_entry_t;

  typedef struct packed {
    logic [31:0] addr;
    word_t       data;
    logic        we;
  } mem_req_t;

endpackage

//--- verilog/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Core byte address fields
`define DC_TAG_HI 18
`define DC_TAG_LO 11
`define DC_IDX_HI 10
`define DC_IDX_LO 2

`define DC_LINES 512

// Upper memory address bits, window starts at 0x4000_0000
`define DC_MEM_BASE 13'h0800

`endif
